// ==== files.f ====
source/l2TilePkg.sv
source/flushControl.sv
source/tileStore.sv
source/missEngine.sv
source/ringLookup.sv
source/l2TileCache.sv
sim/l2TileCacheProperties.sv
sim/l2TileCacheTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = l2TileCacheTb
FILELIST = files.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== sim/l2TileCacheTb.sv ====
`timescale 1ns/1ns

module l2TileCacheTb;
	import l2TilePkg::*;

	localparam int MaxAttempts = 20;
	localparam int CyclesPerAttempt = 40;
	// A and C share hash index 52h
	// B and E each sit on an index of their own
	localparam logic [31:0] AddrA = 32'h0100_0120;
	localparam logic [31:0] AddrB = 32'h0200_0120;
	localparam logic [31:0] AddrC = 32'h0100_4130;
	localparam logic [31:0] AddrE = 32'h0300_0450;
	localparam logic [31:0] AddrFlush = 32'hF000_000E;

	logic clock;
	logic reset;
	logic [RingSeqBits-1:0] ringSeqIn;
	logic [RingOpmBits-1:0] ringOpmIn;
	logic [RingAddrBits-1:0] ringAddrIn;
	logic [TileBits-1:0] ringDataIn;
	logic [RingSeqBits-1:0] ringSeqOut;
	logic [RingOpmBits-1:0] ringOpmOut;
	logic [RingAddrBits-1:0] ringAddrOut;
	logic [TileBits-1:0] ringDataOut;
	logic [TileBits-1:0] ddrDataIn;
	logic [DdrOkBits-1:0] ddrOk;
	logic [DdrAddrBits-1:0] ddrAddr;
	logic [DdrOpmBits-1:0] ddrOpm;
	logic [TileBits-1:0] ddrDataOut;
	logic [RingSeqBits-1:0] seqCount;
	// address of the entry being retried
	logic [31:0] activeAddr;

	// sparse memories keyed by tile address
	logic [TileBits-1:0] ddrMemory [logic [TileAddrBits-1:0]];
	logic [TileBits-1:0] golden [logic [TileAddrBits-1:0]];

	// stimulus table as parallel queues with one entry per index
	logic [RingOpmBits-1:0] tableOpm [$];
	logic [31:0] tableAddr [$];
	logic [TileBits-1:0] tableData [$];
	logic tableAnswer [$];
	logic [31:0] tableVictim [$];

	l2TileCache dut (.*);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// untouched tiles hold a pattern of the whole tile address
	function automatic logic [TileBits-1:0] fillPattern(input logic [TileAddrBits-1:0] tileAddr);
		logic [31:0] a;
		a = {4'h0, tileAddr};
		return {~a, a ^ 32'h3c5a_96e1, a[15:0], a[31:16], a};
	endfunction

	function automatic logic [TileBits-1:0] ddrTile(input logic [TileAddrBits-1:0] tileAddr);
		if (ddrMemory.exists(tileAddr))
			return ddrMemory[tileAddr];
		return fillPattern(tileAddr);
	endfunction

	function automatic logic [TileBits-1:0] goldenTile(input logic [TileAddrBits-1:0] tileAddr);
		if (golden.exists(tileAddr))
			return golden[tileAddr];
		return fillPattern(tileAddr);
	endfunction

	// low ten tile-address bits xor the next ten
	function automatic logic [TileIndexBits-1:0] hashIndex(input logic [31:0] addr);
		logic [TileAddrBits-1:0] tileAddr;
		tileAddr = addr[31:4];
		return tileAddr[9:0] ^ tileAddr[19:10];
	endfunction

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Done: errors found");
		$fatal(1, "run stopped");
	endtask

	task automatic checkValue(input string name, input logic [TileBits-1:0] actual,
		input logic [TileBits-1:0] expected);
		if (actual !== expected)
			abortRun($sformatf("** Error: %s is %h, expected %h", name, actual, expected));
	endtask

	task automatic addEntry(input logic [RingOpmBits-1:0] opm, input logic [31:0] addr,
		input logic [TileBits-1:0] data, input logic answer, input logic [31:0] victim);
		tableOpm.push_back(opm);
		tableAddr.push_back(addr);
		tableData.push_back(data);
		tableAnswer.push_back(answer);
		tableVictim.push_back(victim);
	endtask

	task automatic buildTable();
		addEntry({8'h00, OpmIdle}, 32'h0, 128'h0, 1'b0, 32'h0);
		addEntry({8'h5c, OpmLoadTile}, AddrA, 128'h0, 1'b1, 32'h0);
		addEntry({8'h00, OpmLoadTile}, AddrA, 128'h0, 1'b1, 32'h0);
		addEntry({8'h21, OpmStoreTile}, AddrA, 128'h1111_2222_3333_4444_5555_6666_7777_8888,
			1'b1, 32'h0);
		addEntry({8'h00, OpmLoadTile}, AddrA, 128'h0, 1'b1, 32'h0);
		// conflicting load evicts the dirty A
		addEntry({8'h3a, OpmLoadTile}, AddrC, 128'h0, 1'b1, AddrA);
		addEntry({8'h00, OpmLoadTile}, AddrA, 128'h0, 1'b1, 32'h0);
		addEntry({8'h00, OpmStoreTile}, AddrB, 128'hdead_beef_0123_4567_89ab_cdef_fedc_ba98,
			1'b1, 32'h0);
		addEntry({8'h00, OpmLoadTile}, AddrB, 128'h0, 1'b1, 32'h0);
		addEntry({8'h77, OpmLoadTile}, 32'h0000_1000, 128'h5a5a, 1'b0, 32'h0);
		addEntry({8'h00, OpmStoreTile}, 32'h4100_0000, 128'h0f0f_f0f0, 1'b0, 32'h0);
		addEntry({8'h00, OpmStoreTile}, AddrE, 128'hcafe_f00d_0000_1111_2222_3333_aaaa_5555,
			1'b1, 32'h0);
		addEntry({8'h00, OpmFlush}, AddrFlush, 128'h0, 1'b0, 32'h0);
		addEntry({8'h00, OpmIdle}, 32'h0, 128'h0, 1'b0, 32'h0);
		// stale dirty lines are written back on replacement
		addEntry({8'h00, OpmLoadTile}, AddrB, 128'h0, 1'b1, AddrB);
		addEntry({8'h00, OpmLoadTile}, AddrE, 128'h0, 1'b1, AddrE);
		addEntry({8'h42, OpmStoreTile}, AddrA, 128'h0bad_cafe_1357_9bdf_2468_ace0_feed_face,
			1'b1, 32'h0);
		addEntry({8'h00, OpmFlush}, AddrFlush, 128'h0, 1'b0, 32'h0);
		addEntry({8'h00, OpmLoadTile}, AddrA, 128'h0, 1'b1, AddrA);
		addEntry({8'h00, OpmLoadTile}, AddrC, 128'h0, 1'b1, 32'h0);
		addEntry({8'h00, OpmLoadTile}, 32'h0123_4560, 128'h0, 1'b1, 32'h0);
		addEntry({8'h00, OpmIdle}, 32'h0, 128'h0, 1'b0, 32'h0);
	endtask

	task automatic driveIdle();
		ringSeqIn = '1;
		ringOpmIn = RingOpmIdle;
		ringAddrIn = '0;
		ringDataIn = '0;
	endtask

	// slot goes in now and is on the outputs three edges later
	task automatic sendSlot(input logic [RingOpmBits-1:0] opm, input logic [31:0] addr,
		input logic [TileBits-1:0] data);
		ringSeqIn = seqCount;
		ringOpmIn = opm;
		ringAddrIn = {seqCount, addr};
		ringDataIn = data;
		repeat (3)
		begin
			@(posedge clock);
			#1;
			driveIdle();
		end
	endtask

	task automatic runEntry(input int entry);
		logic [RingOpmBits-1:0] okOpm;
		logic [TileAddrBits-1:0] tileAddr;
		logic isStore;
		logic answered;
		int attempt;
		activeAddr = tableAddr[entry];
		tileAddr = tableAddr[entry][31:4];
		isStore = (tableOpm[entry][7:0] == OpmStoreTile);
		okOpm = {tableOpm[entry][15:8], isStore ? OpmOkStore : OpmOkLoad};
		answered = 1'b0;
		attempt = 0;
		while (!answered)
		begin
			if (attempt == MaxAttempts)
				abortRun($sformatf("entry %0d got no answer in %0d attempts", entry, attempt));
			sendSlot(tableOpm[entry], tableAddr[entry], tableData[entry]);
			checkValue("ringSeqOut", TileBits'(ringSeqOut), TileBits'(seqCount));
			checkValue("ringAddrOut", TileBits'(ringAddrOut),
				TileBits'({seqCount, tableAddr[entry]}));
			if (!tableAnswer[entry] || ringOpmOut == tableOpm[entry])
			begin
				// unchanged slot means a miss that is retried
				checkValue("ringOpmOut", TileBits'(ringOpmOut), TileBits'(tableOpm[entry]));
				checkValue("ringDataOut", ringDataOut, tableData[entry]);
				answered = !tableAnswer[entry];
			end
			else
			begin
				checkValue("ringOpmOut", TileBits'(ringOpmOut), TileBits'(okOpm));
				if (isStore)
					golden[tileAddr] = tableData[entry];
				else
					checkValue("ringDataOut", ringDataOut, goldenTile(tileAddr));
				answered = 1'b1;
			end
			seqCount++;
			attempt++;
		end
		// evicted line must have reached DDR
		if (tableVictim[entry] != 32'h0)
			checkValue("ddrMemory", ddrTile(tableVictim[entry][31:4]),
				goldenTile(tableVictim[entry][31:4]));
	endtask

	// DDR model gives a random hold then one OK cycle
	initial
	begin
		int holdCycles;
		logic [TileAddrBits-1:0] tileAddr;
		ddrOk = DdrStatusReady;
		ddrDataIn = '0;
		forever
		begin
			@(posedge clock);
			#1;
			if (!reset && ddrOk == DdrStatusReady && ddrOpm != DdrReady)
			begin
				tileAddr = ddrAddr[31:4];
				holdCycles = $urandom % 4;
				if (holdCycles > 0)
					ddrOk = DdrStatusHold;
				repeat (holdCycles)
				begin
					@(posedge clock);
					#1;
				end
				if (ddrOpm == DdrWriteTile)
				begin
					// write-back carries the golden tile of a line on the retried index
					checkValue("ddrDataOut", ddrDataOut, goldenTile(tileAddr));
					checkValue("ddrAddr index", TileBits'(hashIndex(ddrAddr)),
						TileBits'(hashIndex(activeAddr)));
					ddrMemory[tileAddr] = ddrDataOut;
				end
				else
					ddrDataIn = ddrTile(tileAddr);
				ddrOk = DdrStatusOk;
				@(posedge clock);
				#1;
				ddrOk = DdrStatusReady;
			end
		end
	end

	initial
	begin
		int limitCycles;
		#1;
		limitCycles = tableOpm.size() * MaxAttempts * CyclesPerAttempt;
		repeat (limitCycles) @(posedge clock);
		abortRun($sformatf("watchdog expired after %0d cycles without finishing", limitCycles));
	end

	initial
	begin
		void'($urandom(32'hb8ebc3f2));
		reset = 1'b1;
		seqCount = '0;
		activeAddr = '0;
		driveIdle();
		buildTable();
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;
		for (int i = 0; i < tableOpm.size(); i++)
			runEntry(i);
		$display("Done: no errors");
		$finish;
	end

endmodule

// ==== sim/l2TileCacheProperties.sv ====
`timescale 1ns/1ns

module l2TileCacheProperties (
	input  logic clock,
	input  logic reset,
	input  logic [l2TilePkg::RingOpmBits-1:0] ringOpmIn,
	input  logic [l2TilePkg::RingAddrBits-1:0] ringAddrIn,
	input  logic [l2TilePkg::RingOpmBits-1:0] ringOpmOut,
	input  logic [l2TilePkg::DdrOpmBits-1:0] ddrOpm,
	input  logic [l2TilePkg::DdrOkBits-1:0] ddrOk
);
	import l2TilePkg::*;

	logic ramRequestIn;
	logic okOut;

	// RAM-region tile load or store entering the ring
	assign ramRequestIn = (ringAddrIn[29:24] != RamSelectNone) &&
		(ringAddrIn[31:30] == RamTopRequired) &&
		((ringOpmIn[7:0] == OpmLoadTile) || (ringOpmIn[7:0] == OpmStoreTile));
	assign okOut = (ringOpmOut[7:0] == OpmOkLoad) || (ringOpmOut[7:0] == OpmOkStore);

	holdKeepsCommand: assert property (@(posedge clock) disable iff (reset)
		ddrOk == DdrStatusHold |=> $stable(ddrOpm))
		else $error("DDR command changed while the port held it");

	resetClearsRing: assert property (@(posedge clock) reset |=> ringOpmOut == RingOpmIdle)
		else $error("ring output not idle after reset");

	okFollowsRequest: assert property (@(posedge clock) disable iff (reset)
		okOut |-> $past(ramRequestIn, 3))
		else $error("OK code without a RAM request three cycles earlier");

endmodule

bind l2TileCache l2TileCacheProperties properties (.*);

// ==== source/l2TileCache.sv ====
`timescale 1ns/1ns

module l2TileCache (
	input  logic clock,
	input  logic reset,
	input  logic [l2TilePkg::RingSeqBits-1:0] ringSeqIn,
	input  logic [l2TilePkg::RingOpmBits-1:0] ringOpmIn,
	input  logic [l2TilePkg::RingAddrBits-1:0] ringAddrIn,
	input  logic [l2TilePkg::TileBits-1:0] ringDataIn,
	output logic [l2TilePkg::RingSeqBits-1:0] ringSeqOut,
	output logic [l2TilePkg::RingOpmBits-1:0] ringOpmOut,
	output logic [l2TilePkg::RingAddrBits-1:0] ringAddrOut,
	output logic [l2TilePkg::TileBits-1:0] ringDataOut,
	input  logic [l2TilePkg::TileBits-1:0] ddrDataIn,
	input  logic [l2TilePkg::DdrOkBits-1:0] ddrOk,
	output logic [l2TilePkg::DdrAddrBits-1:0] ddrAddr,
	output logic [l2TilePkg::DdrOpmBits-1:0] ddrOpm,
	output logic [l2TilePkg::TileBits-1:0] ddrDataOut
);
	import l2TilePkg::*;

	logic [GenerationBits-1:0] generation;

	// tile store ports
	logic [TileIndexBits-1:0] readIndex;
	logic [TileBits-1:0] readTile;
	logic [TileAddrBits-1:0] readTag;
	logic [GenerationBits-1:0] readGeneration;
	logic readDirty;
	logic writeEnable;
	logic [TileIndexBits-1:0] writeIndex;
	logic [TileBits-1:0] writeTile;
	logic [TileAddrBits-1:0] writeTag;
	logic [GenerationBits-1:0] writeGeneration;
	logic writeDirty;

	// miss request and fill return
	logic missStart;
	logic [TileIndexBits-1:0] missIndex;
	logic [TileAddrBits-1:0] missTag;
	logic [TileBits-1:0] victimTile;
	logic [TileAddrBits-1:0] victimTag;
	logic victimDirty;
	logic missBusy;
	logic fillValid;
	logic [TileIndexBits-1:0] fillIndex;
	logic [TileAddrBits-1:0] fillTag;
	logic [TileBits-1:0] fillTile;

	flushControl flush (.*);

	ringLookup lookup (.*);

	tileStore store (.*);

	missEngine miss (.*);

endmodule

// ==== source/ringLookup.sv ====
`timescale 1ns/1ns

module ringLookup (
	input  logic clock,
	input  logic reset,
	input  logic [l2TilePkg::RingSeqBits-1:0] ringSeqIn,
	input  logic [l2TilePkg::RingOpmBits-1:0] ringOpmIn,
	input  logic [l2TilePkg::RingAddrBits-1:0] ringAddrIn,
	input  logic [l2TilePkg::TileBits-1:0] ringDataIn,
	output logic [l2TilePkg::RingSeqBits-1:0] ringSeqOut,
	output logic [l2TilePkg::RingOpmBits-1:0] ringOpmOut,
	output logic [l2TilePkg::RingAddrBits-1:0] ringAddrOut,
	output logic [l2TilePkg::TileBits-1:0] ringDataOut,
	input  logic [l2TilePkg::GenerationBits-1:0] generation,
	output logic [l2TilePkg::TileIndexBits-1:0] readIndex,
	input  logic [l2TilePkg::TileBits-1:0] readTile,
	input  logic [l2TilePkg::TileAddrBits-1:0] readTag,
	input  logic [l2TilePkg::GenerationBits-1:0] readGeneration,
	input  logic readDirty,
	output logic writeEnable,
	output logic [l2TilePkg::TileIndexBits-1:0] writeIndex,
	output logic [l2TilePkg::TileBits-1:0] writeTile,
	output logic [l2TilePkg::TileAddrBits-1:0] writeTag,
	output logic [l2TilePkg::GenerationBits-1:0] writeGeneration,
	output logic writeDirty,
	output logic missStart,
	output logic [l2TilePkg::TileIndexBits-1:0] missIndex,
	output logic [l2TilePkg::TileAddrBits-1:0] missTag,
	output logic [l2TilePkg::TileBits-1:0] victimTile,
	output logic [l2TilePkg::TileAddrBits-1:0] victimTag,
	output logic victimDirty,
	input  logic missBusy,
	input  logic fillValid,
	input  logic [l2TilePkg::TileIndexBits-1:0] fillIndex,
	input  logic [l2TilePkg::TileAddrBits-1:0] fillTag,
	input  logic [l2TilePkg::TileBits-1:0] fillTile
);
	import l2TilePkg::*;

	logic [TileAddrBits-1:0] tileAddrIn;
	logic inRam;
	logic [RingSeqBits-1:0] s1Seq;
	logic [RingOpmBits-1:0] s1Opm;
	logic [RingAddrBits-1:0] s1Addr;
	logic [TileBits-1:0] s1Data;
	logic [TileIndexBits-1:0] s1Index;
	logic s1Load;
	logic s1Store;
	logic [TileAddrBits-1:0] s1Tag;
	logic hit;
	logic hazard;
	logic storeAllocate;
	logic loadAnswer;
	logic storeAnswer;
	logic lastWriteEnable;
	logic [TileIndexBits-1:0] lastWriteIndex;
	logic [RingSeqBits-1:0] s2Seq;
	logic [RingOpmBits-1:0] s2Opm;
	logic [RingAddrBits-1:0] s2Addr;
	logic [TileBits-1:0] s2Data;
	logic [TileBits-1:0] s2Tile;
	logic s2Answer;
	logic s2Store;

	// index hash folds two ten-bit slices of the tile address
	assign tileAddrIn = ringAddrIn[31:4];
	assign readIndex = tileAddrIn[TileIndexBits-1:0] ^ tileAddrIn[2*TileIndexBits-1:TileIndexBits];
	assign inRam = (ringAddrIn[29:24] != RamSelectNone) && (ringAddrIn[31:30] == RamTopRequired);

	always_ff @(posedge clock)
	begin
		s1Seq <= ringSeqIn;
		s1Addr <= ringAddrIn;
		s1Data <= ringDataIn;
		s1Index <= readIndex;
		if (reset)
		begin
			s1Opm <= RingOpmIdle;
			s1Load <= 1'b0;
			s1Store <= 1'b0;
		end
		else
		begin
			s1Opm <= ringOpmIn;
			s1Load <= inRam && (ringOpmIn[OpmCodeBits-1:0] == OpmLoadTile);
			s1Store <= inRam && (ringOpmIn[OpmCodeBits-1:0] == OpmStoreTile);
		end
	end

	// stage 2 sees the line read for this slot
	assign s1Tag = s1Addr[31:4];
	assign hit = (readTag == s1Tag) && (readGeneration == generation);
	// read data is stale if this index was just written or is being refilled
	assign hazard = fillValid || (lastWriteEnable && (lastWriteIndex == s1Index)) ||
		(missBusy && (fillIndex == s1Index));
	assign storeAllocate = s1Store && (hit || !readDirty);
	assign loadAnswer = s1Load && hit && !hazard;
	assign storeAnswer = storeAllocate && !hazard;
	assign missStart = ((s1Load && !hit) || (s1Store && !storeAllocate)) && !hazard && !missBusy;

	assign missIndex = s1Index;
	assign missTag = s1Tag;
	assign victimTile = readTile;
	assign victimTag = readTag;
	assign victimDirty = readDirty;

	// refill wins the write port
	always_comb
	begin
		writeEnable = fillValid || storeAnswer;
		writeGeneration = generation;
		if (fillValid)
		begin
			writeIndex = fillIndex;
			writeTile = fillTile;
			writeTag = fillTag;
			writeDirty = 1'b0;
		end
		else
		begin
			writeIndex = s1Index;
			writeTile = s1Data;
			writeTag = s1Tag;
			writeDirty = 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		s2Seq <= s1Seq;
		s2Addr <= s1Addr;
		s2Data <= s1Data;
		s2Tile <= readTile;
		s2Store <= s1Store;
		lastWriteIndex <= writeIndex;
		if (reset)
		begin
			s2Opm <= RingOpmIdle;
			s2Answer <= 1'b0;
			lastWriteEnable <= 1'b0;
		end
		else
		begin
			s2Opm <= s1Opm;
			s2Answer <= loadAnswer || storeAnswer;
			lastWriteEnable <= writeEnable;
		end
	end

	// stage 3, answered slots carry the old tile and an OK code
	always_ff @(posedge clock)
	begin
		ringSeqOut <= s2Seq;
		ringAddrOut <= s2Addr;
		ringDataOut <= s2Answer ? s2Tile : s2Data;
		if (reset)
			ringOpmOut <= RingOpmIdle;
		else if (s2Answer)
			ringOpmOut <= {s2Opm[RingOpmBits-1:OpmCodeBits], s2Store ? OpmOkStore : OpmOkLoad};
		else
			ringOpmOut <= s2Opm;
	end

endmodule

// ==== source/missEngine.sv ====
`timescale 1ns/1ns

module missEngine (
	input  logic clock,
	input  logic reset,
	input  logic missStart,
	input  logic [l2TilePkg::TileIndexBits-1:0] missIndex,
	input  logic [l2TilePkg::TileAddrBits-1:0] missTag,
	input  logic [l2TilePkg::TileBits-1:0] victimTile,
	input  logic [l2TilePkg::TileAddrBits-1:0] victimTag,
	input  logic victimDirty,
	output logic missBusy,
	output logic fillValid,
	output logic [l2TilePkg::TileIndexBits-1:0] fillIndex,
	output logic [l2TilePkg::TileAddrBits-1:0] fillTag,
	output logic [l2TilePkg::TileBits-1:0] fillTile,
	output logic [l2TilePkg::DdrAddrBits-1:0] ddrAddr,
	output logic [l2TilePkg::DdrOpmBits-1:0] ddrOpm,
	output logic [l2TilePkg::TileBits-1:0] ddrDataOut,
	input  logic [l2TilePkg::TileBits-1:0] ddrDataIn,
	input  logic [l2TilePkg::DdrOkBits-1:0] ddrOk
);
	import l2TilePkg::*;

	logic [MissStateBits-1:0] state;
	logic readyToIssue;
	logic ddrDone;

	assign missBusy = (state != MissIdle);
	assign fillValid = (state == MissFill);
	// new command only from a quiet port, completion on OK
	assign readyToIssue = (ddrOpm == DdrReady) && (ddrOk == DdrStatusReady);
	assign ddrDone = (ddrOpm != DdrReady) && (ddrOk == DdrStatusOk);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= MissIdle;
			ddrOpm <= DdrReady;
		end
		else
		begin
			case (state)
				MissIdle:
				begin
					if (missStart)
					begin
						fillIndex <= missIndex;
						fillTag <= missTag;
						ddrDataOut <= victimTile;
						ddrAddr <= {victimDirty ? victimTag : missTag, 4'b0000};
						state <= victimDirty ? MissWriteBack : MissRead;
					end
				end
				MissWriteBack:
				begin
					if (readyToIssue)
						ddrOpm <= DdrWriteTile;
					else if (ddrDone)
					begin
						ddrOpm <= DdrReady;
						state <= MissWaitReady;
					end
				end
				// let the port settle before the refill read
				MissWaitReady:
				begin
					if (ddrOk == DdrStatusReady)
					begin
						ddrAddr <= {fillTag, 4'b0000};
						state <= MissRead;
					end
				end
				MissRead:
				begin
					if (readyToIssue)
						ddrOpm <= DdrReadTile;
					else if (ddrDone)
					begin
						fillTile <= ddrDataIn;
						ddrOpm <= DdrReady;
						state <= MissFill;
					end
				end
				default:
					state <= MissIdle;
			endcase
		end
	end

endmodule

// ==== source/tileStore.sv ====
`timescale 1ns/1ns

module tileStore (
	input  logic clock,
	input  logic [l2TilePkg::TileIndexBits-1:0] readIndex,
	input  logic writeEnable,
	input  logic [l2TilePkg::TileIndexBits-1:0] writeIndex,
	input  logic [l2TilePkg::TileBits-1:0] writeTile,
	input  logic [l2TilePkg::TileAddrBits-1:0] writeTag,
	input  logic [l2TilePkg::GenerationBits-1:0] writeGeneration,
	input  logic writeDirty,
	output logic [l2TilePkg::TileBits-1:0] readTile,
	output logic [l2TilePkg::TileAddrBits-1:0] readTag,
	output logic [l2TilePkg::GenerationBits-1:0] readGeneration,
	output logic readDirty
);
	import l2TilePkg::*;

	logic [TileBits-1:0] tileArray [TileLines];
	// each tag entry packs tile address, generation and dirty bit
	logic [TagEntryBits-1:0] tagArray [TileLines];

	// generation zero marks an empty line
	initial
	begin
		for (int i = 0; i < TileLines; i++)
		begin
			tileArray[i] = '0;
			tagArray[i] = '0;
		end
	end

	always_ff @(posedge clock)
	begin
		readTile <= tileArray[readIndex];
		{readTag, readGeneration, readDirty} <= tagArray[readIndex];
		if (writeEnable)
		begin
			tileArray[writeIndex] <= writeTile;
			tagArray[writeIndex] <= {writeTag, writeGeneration, writeDirty};
		end
	end

endmodule

// ==== source/flushControl.sv ====
`timescale 1ns/1ns

module flushControl (
	input  logic clock,
	input  logic reset,
	input  logic [l2TilePkg::RingOpmBits-1:0] ringOpmIn,
	input  logic [l2TilePkg::RingAddrBits-1:0] ringAddrIn,
	output logic [l2TilePkg::GenerationBits-1:0] generation
);
	import l2TilePkg::*;

	logic flushSeen;
	logic [GenerationBits-1:0] nextGeneration;

	// zero is reserved for empty lines
	assign nextGeneration = (generation == '1) ? GenerationFirst : generation + GenerationBits'(1);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			flushSeen <= 1'b0;
			generation <= GenerationFirst;
		end
		else
		begin
			flushSeen <= (ringOpmIn[OpmCodeBits-1:0] == OpmFlush) &&
				(ringAddrIn[31:28] == FlushAddrTop) && (ringAddrIn[3:0] == FlushAddrLow);
			if (flushSeen)
				generation <= nextGeneration;
		end
	end

endmodule

// ==== source/l2TilePkg.sv ====
package l2TilePkg;

	// ring slot fields
	localparam int RingSeqBits = 16;
	localparam int RingOpmBits = 16;
	localparam int RingAddrBits = 48;
	localparam int TileBits = 128;

	// tile address is ring address bits 31:4
	localparam int TileAddrBits = 28;
	localparam int TileIndexBits = 10;
	localparam int TileLines = 1 << TileIndexBits;
	localparam int GenerationBits = 4;
	localparam int TagEntryBits = TileAddrBits + GenerationBits + 1;

	// only the low byte of the operation mode is decoded
	localparam int OpmCodeBits = 8;
	localparam logic [OpmCodeBits-1:0] OpmIdle = 8'h00;
	localparam logic [OpmCodeBits-1:0] OpmLoadTile = 8'h93;
	localparam logic [OpmCodeBits-1:0] OpmStoreTile = 8'hA3;
	localparam logic [OpmCodeBits-1:0] OpmOkLoad = 8'h60;
	localparam logic [OpmCodeBits-1:0] OpmOkStore = 8'h70;
	localparam logic [OpmCodeBits-1:0] OpmFlush = 8'hF1;
	localparam logic [RingOpmBits-1:0] RingOpmIdle = {8'h00, OpmIdle};

	// flush slot marker in address bits 31:28 and 3:0
	localparam logic [3:0] FlushAddrTop = 4'hF;
	localparam logic [3:0] FlushAddrLow = 4'hE;

	// RAM when bits 29:24 differ from this and bits 31:30 equal RamTopRequired
	localparam logic [5:0] RamSelectNone = 6'h00;
	localparam logic [1:0] RamTopRequired = 2'b00;

	localparam logic [GenerationBits-1:0] GenerationFirst = 4'h1;

	// DDR port
	localparam int DdrAddrBits = 32;
	localparam int DdrOpmBits = 5;
	localparam int DdrOkBits = 2;
	localparam logic [DdrOpmBits-1:0] DdrReady = 5'b00000;
	localparam logic [DdrOpmBits-1:0] DdrReadTile = 5'b10111;
	localparam logic [DdrOpmBits-1:0] DdrWriteTile = 5'b11111;
	localparam logic [DdrOkBits-1:0] DdrStatusReady = 2'b00;
	localparam logic [DdrOkBits-1:0] DdrStatusOk = 2'b01;
	localparam logic [DdrOkBits-1:0] DdrStatusHold = 2'b10;

	// miss engine states
	localparam int MissStateBits = 3;
	localparam logic [MissStateBits-1:0] MissIdle = 3'd0;
	localparam logic [MissStateBits-1:0] MissWriteBack = 3'd1;
	localparam logic [MissStateBits-1:0] MissWaitReady = 3'd2;
	localparam logic [MissStateBits-1:0] MissRead = 3'd3;
	localparam logic [MissStateBits-1:0] MissFill = 3'd4;

endpackage
